/* icache_golden.hex */
// cmd_addr_instr0_instr1_slots_adef_refills, cmd 0 fetch, 1 fetch then flush
// cmd 2 fetch and issue the next record without waiting, f ends the list
0_00000100_ffff0100_ffff0104_3_0_01
0_00000108_ffff0108_ffff010c_3_0_00
2_00000100_ffff0100_ffff0104_3_0_00
0_0000010c_ffff0108_ffff010c_3_0_00
0_00000140_ffff0140_ffff0144_3_0_01
0_00000100_ffff0100_ffff0104_3_0_00
0_00000180_ffff0180_ffff0184_3_0_01
0_00000104_ffff0100_ffff0104_3_0_00
0_00000148_ffff0148_ffff014c_3_0_01
0_00000102_00000000_00000000_0_1_00
0_00000211_00000000_00000000_0_1_00
1_00000210_00000000_00000000_0_0_01
0_00000210_ffff0210_ffff0214_3_0_01
0_12345670_edcb5670_edcb5674_3_0_01
0_12345678_edcb5678_edcb567c_3_0_00
2_12345670_edcb5670_edcb5674_3_0_00
0_12345678_edcb5678_edcb567c_3_0_00
0_8000a020_7fffa020_7fffa024_3_0_01
0_8000a028_7fffa028_7fffa02c_3_0_00
1_0000a0a0_00000000_00000000_0_0_01
0_8000a024_7fffa020_7fffa024_3_0_00
0_0000a0a8_ffffa0a8_ffffa0ac_3_0_01
0_8000a02c_7fffa028_7fffa02c_3_0_00
2_0000a0a0_ffffa0a0_ffffa0a4_3_0_00
0_0000a0a8_ffffa0a8_ffffa0ac_3_0_00
0_fffffffc_0000fff8_0000fffc_3_0_01
0_12345674_edcb5670_edcb5674_3_0_00
0_00000003_00000000_00000000_0_1_00
0_000001c4_ffff01c0_ffff01c4_3_0_01
0_00000140_ffff0140_ffff0144_3_0_00
0_00000100_ffff0100_ffff0104_3_0_01
f_00000000_00000000_00000000_0_0_00

/* vlog.f */
icache_pkg.sv
sdp_ram.sv
icache_ways.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_icache \
  -o sim_icache > build.log 2>&1 \
  && ./obj_dir/sim_icache > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "FAIL: see errors above" sim.log \
  && { echo "simulation reported errors, see sim.log"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

/* tb_icache.sv */
`timescale 1ns/100ps

module tb_icache import icache_pkg::*;;

  localparam int SET_NUM    = 4;
  localparam int LINE_WORDS = 4;
  localparam int MAX_REC    = 64;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  logic       flush_i = 1'b0;
  logic       req_valid_i = 1'b0;
  fetch_req_t req_i = '0;
  logic       req_ready_o;
  logic       rsp_valid_o;
  fetch_rsp_t rsp_o;
  logic       rsp_ready_i = 1'b0;
  logic       ar_valid_o;
  axi_ar_t    ar_o;
  logic       ar_ready_i = 1'b0;
  logic       r_valid_i = 1'b0;
  axi_r_t     r_i = '0;
  logic       r_ready_o;

  // cmd, addr, instr0, instr1, slot valid, error flag, refill count
  logic [115:0] golden [MAX_REC];
  int           n_rec = 0;
  int           err_cnt = 0;
  int           ar_count = 0;
  int           burst_done = 0;
  int           overlap_cnt = 0;
  int           exp_q[$];
  int           start_q[$];
  string        cur_name = "reset";
  logic [31:0]  cur_addr = '0;

  // handshakes sampled just before the rising edge
  logic        req_hs = 1'b0;
  logic        ar_hs = 1'b0;
  logic        r_hs = 1'b0;
  logic [31:0] ar_addr_s = '0;

  // memory model state
  logic        burst_on = 1'b0;
  logic [31:0] burst_addr = '0;
  int          beat = 0;
  logic [15:0] lfsr = 16'd57;

  icache_top #(
    .SET_NUM    (SET_NUM),
    .LINE_WORDS (LINE_WORDS)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i),
    .ar_valid_o  (ar_valid_o),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o)
  );

  always #50 clk = ~clk;

  // word at byte address a, upper half inverted
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {~a[31:16], a[15:0]};
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // ============================================================
  // axi memory model and random gaps
  // ============================================================
  always @(negedge clk) begin
    if (ar_hs) begin
      burst_on   = 1'b1;
      burst_addr = ar_addr_s;
      beat       = 0;
    end
    if (r_hs) begin
      if (beat == LINE_WORDS - 1) begin
        burst_on = 1'b0;
        burst_done++;
      end else begin
        beat++;
      end
    end
    lfsr = lfsr_step(lfsr);
    ar_ready_i = lfsr[0];
    lfsr = lfsr_step(lfsr);
    r_valid_i = burst_on && lfsr[0];
    r_i.data  = mem_word(burst_addr + 32'(4 * beat));
    r_i.last  = (beat == LINE_WORDS - 1);
    lfsr = lfsr_step(lfsr);
    rsp_ready_i = lfsr[0];
    lfsr = lfsr_step(lfsr);
    rsp_ready_i = rsp_ready_i | lfsr[0];
  end

  // ============================================================
  // sampler and response checker
  // ============================================================
  always begin
    int          idx;
    int          errs;
    logic [115:0] rec;
    logic [31:0] exp_addr;
    @(negedge clk);
    #45;
    req_hs    = req_valid_i && req_ready_o;
    ar_hs     = ar_valid_o && ar_ready_i;
    r_hs      = r_valid_i && r_ready_o;
    ar_addr_s = ar_o.addr;
    // a new request taken while the previous response leaves
    if (req_hs && rsp_valid_o && rsp_ready_i) begin
      overlap_cnt++;
    end
    if (ar_hs) begin
      ar_count++;
      check_value({cur_name, " ar len"}, 64'(LINE_WORDS - 1), 64'(ar_o.len));
      check_value({cur_name, " ar burst"}, 64'(INCR), 64'(ar_o.burst));
      check_value({cur_name, " ar size"}, 64'd2, 64'(ar_o.size));
      check_value({cur_name, " ar addr"}, 64'(cur_addr & ~32'(LINE_WORDS * 4 - 1)),
                  64'(ar_o.addr));
    end
    if (rst_n && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("unexpected response for address %h with no request pending", rsp_o.vaddr);
        err_cnt++;
      end else begin
        idx  = exp_q.pop_front();
        rec  = golden[idx];
        errs = err_cnt;
        // error responses carry the faulting address, others the group base
        exp_addr = (rec[11:8] != 4'h0) ? rec[111:80]
                                       : rec[111:80] & ~32'(FETCH_WIDTH * 4 - 1);
        check_value($sformatf("test %0d addr", idx), 64'(exp_addr), 64'(rsp_o.vaddr));
        check_value($sformatf("test %0d instr", idx), {rec[47:16], rec[79:48]}, rsp_o.instr);
        check_value($sformatf("test %0d slots", idx), 64'(rec[15:12]), 64'(rsp_o.slot_valid));
        check_value($sformatf("test %0d adef", idx), 64'(rec[11:8]), 64'(rsp_o.adef));
        check_value($sformatf("test %0d refills", idx), 64'(rec[7:0]),
                    64'(ar_count - start_q.pop_front()));
        $display("test %0d addr %h: %s", idx, rec[111:80], (errs == err_cnt) ? "ok" : "mismatch");
      end
    end
  end

  // ============================================================
  // golden file driver
  // ============================================================
  initial begin
    logic [115:0] rec;
    int           done_before;
    int           cnt_before;
    int           n_pipe;
    n_pipe = 0;
    $readmemh("icache_golden.hex", golden);
    while (n_rec < MAX_REC && golden[n_rec][115:112] !== 4'hf) begin
      n_rec++;
    end
    if (n_rec == MAX_REC || n_rec == 0) begin
      $display("golden file missing or has no end record");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < n_rec; i++) begin
        rec      = golden[i];
        cur_name = $sformatf("test %0d", i);
        cur_addr = rec[111:80];
        req_valid_i = 1'b1;
        req_i.vaddr = rec[111:80];
        @(negedge clk);
        while (!req_hs) @(negedge clk);
        req_valid_i = 1'b0;
        if (rec[115:112] == 4'h1) begin
          cnt_before  = ar_count;
          done_before = burst_done;
          // flush once the refill is under way
          @(negedge clk);
          flush_i = 1'b1;
          @(negedge clk);
          flush_i = 1'b0;
          while (burst_done == done_before) @(negedge clk);
          repeat (3) @(negedge clk);
          check_value({cur_name, " refills"}, 64'(rec[7:0]), 64'(ar_count - cnt_before));
          $display("test %0d addr %h: flushed", i, rec[111:80]);
        end else begin
          exp_q.push_back(i);
          start_q.push_back(ar_count);
          if (rec[115:112] == 4'h2) begin
            // next request is offered while this one sits in stage 1
            if (i + 1 < n_rec) begin
              n_pipe++;
            end
          end else begin
            while (exp_q.size() != 0) @(negedge clk);
          end
        end
      end
      repeat (5) @(negedge clk);
      check_value("pipelined accepts", 64'(n_pipe), 64'(overlap_cnt));
      $display("tests %0d, errors %0d", n_rec, err_cnt);
      if (err_cnt == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

  // watchdog sized from the record count
  initial begin
    wait (n_rec > 0);
    #(n_rec * 200 * 100);
    $display("timeout: the cache stopped answering, run aborted during %s", cur_name);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* icache_top.sv */
`timescale 1ns/100ps

module icache_top import icache_pkg::*; #(
  parameter int SET_NUM    = 64,
  parameter int LINE_WORDS = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  // fetch
  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  input  logic       rsp_ready_i,
  // axi read
  output logic       ar_valid_o,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  input  logic       r_valid_i,
  input  axi_r_t     r_i,
  output logic       r_ready_o
);

  localparam int IDX_W = $clog2(SET_NUM);
  localparam int OFS_W = $clog2(LINE_WORDS) + 2;
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

  // ============================================================
  // internal wiring
  // ============================================================
  logic [IDX_W-1:0]                        rd_idx;
  logic [WAY_NUM-1:0][TAG_W-1:0]           tag_rd;
  logic [WAY_NUM-1:0]                      valid_rd;
  logic [WAY_NUM-1:0][LINE_WORDS-1:0][31:0] line_rd;
  logic                                    plru_rd;
  logic                                    plru_we;
  logic                                    plru_wdata;
  logic                                    miss;
  logic [ADDR_W-1:0]                       miss_addr;
  logic                                    victim_way;
  logic                                    refill_busy;
  logic                                    way_we;
  logic                                    way_sel;
  logic [IDX_W-1:0]                        way_idx;
  logic [TAG_W-1:0]                        way_tag;
  logic [LINE_WORDS-1:0][31:0]             refill_line;

  icache_lookup #(
    .SET_NUM    (SET_NUM),
    .LINE_WORDS (LINE_WORDS)
  ) u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .rd_idx_o      (rd_idx),
    .tag_rd_i      (tag_rd),
    .valid_rd_i    (valid_rd),
    .line_rd_i     (line_rd),
    .plru_rd_i     (plru_rd),
    .plru_we_o     (plru_we),
    .plru_wdata_o  (plru_wdata),
    .miss_o        (miss),
    .miss_addr_o   (miss_addr),
    .victim_way_o  (victim_way),
    .refill_busy_i (refill_busy)
  );

  icache_refill #(
    .SET_NUM    (SET_NUM),
    .LINE_WORDS (LINE_WORDS)
  ) u_refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .miss_i        (miss),
    .miss_addr_i   (miss_addr),
    .victim_way_i  (victim_way),
    .refill_busy_o (refill_busy),
    .ar_valid_o    (ar_valid_o),
    .ar_o          (ar_o),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_i           (r_i),
    .r_ready_o     (r_ready_o),
    .way_we_o      (way_we),
    .way_sel_o     (way_sel),
    .way_idx_o     (way_idx),
    .way_tag_o     (way_tag),
    .line_o        (refill_line)
  );

  icache_ways #(
    .SET_NUM    (SET_NUM),
    .LINE_WORDS (LINE_WORDS)
  ) u_ways (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_idx_i     (rd_idx),
    .tag_rd_o     (tag_rd),
    .valid_rd_o   (valid_rd),
    .line_rd_o    (line_rd),
    .plru_rd_o    (plru_rd),
    .way_we_i     (way_we),
    .way_sel_i    (way_sel),
    .way_idx_i    (way_idx),
    .way_tag_i    (way_tag),
    .line_i       (refill_line),
    .plru_we_i    (plru_we),
    .plru_wdata_i (plru_wdata)
  );

endmodule

/* icache_refill.sv */
`timescale 1ns/100ps

module icache_refill import icache_pkg::*; #(
  parameter int SET_NUM    = 64,
  parameter int LINE_WORDS = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush_i,
  // from lookup
  input  logic                           miss_i,
  input  logic [ADDR_W-1:0]              miss_addr_i,
  input  logic                           victim_way_i,
  output logic                           refill_busy_o,
  // axi read channels
  output logic                           ar_valid_o,
  output axi_ar_t                        ar_o,
  input  logic                           ar_ready_i,
  input  logic                           r_valid_i,
  input  axi_r_t                         r_i,
  output logic                           r_ready_o,
  // line write to the ways
  output logic                           way_we_o,
  output logic                           way_sel_o,
  output logic [$clog2(SET_NUM)-1:0]     way_idx_o,
  output logic [ADDR_W-$clog2(SET_NUM)-$clog2(LINE_WORDS)-3:0] way_tag_o,
  output logic [LINE_WORDS-1:0][31:0]    line_o
);

  localparam int IDX_W = $clog2(SET_NUM);
  localparam int OFS_W = $clog2(LINE_WORDS) + 2;
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
  localparam int CNT_W = $clog2(LINE_WORDS);

  refill_state_e               state_q;
  logic [ADDR_W-1:0]           line_addr_q;
  logic                        victim_q;
  logic                        flushed_q;
  logic [CNT_W-1:0]            beat_cnt_q;
  logic [LINE_WORDS-2:0][31:0] beat_buf_q;
  logic                        beat_fire;
  logic                        last_beat;

  assign beat_fire = (state_q == REFILL) && r_valid_i;
  assign last_beat = beat_fire && (beat_cnt_q == CNT_W'(LINE_WORDS - 1));

  // ============================================================
  // control
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
      flushed_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_i && !flush_i) begin
            state_q <= MISS;
          end
        end
        MISS: begin
          if (ar_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (last_beat) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase

      if (beat_fire) begin
        beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
      end

      // burst still runs to the end, only the write is dropped
      if (state_q == IDLE) begin
        flushed_q <= 1'b0;
      end else if (flush_i) begin
        flushed_q <= 1'b1;
      end
    end
  end

  // ============================================================
  // payload
  // ============================================================
  always_ff @(posedge clk) begin
    if (state_q == IDLE && miss_i) begin
      line_addr_q <= miss_addr_i;
      victim_q    <= victim_way_i;
    end
    if (beat_fire && !last_beat) begin
      beat_buf_q[beat_cnt_q] <= r_i.data;
    end
  end

  assign refill_busy_o = state_q != IDLE;

  // one line as an incrementing burst of words
  assign ar_valid_o    = state_q == MISS;
  assign ar_o.addr     = line_addr_q;
  assign ar_o.len      = 8'(LINE_WORDS - 1);
  assign ar_o.size     = 3'b010;
  assign ar_o.burst    = INCR;
  assign r_ready_o     = state_q == REFILL;

  // write in the last beat cycle, final word straight from the bus
  assign way_we_o  = last_beat && !flushed_q && !flush_i;
  assign way_sel_o = victim_q;
  assign way_idx_o = line_addr_q[OFS_W +: IDX_W];
  assign way_tag_o = line_addr_q[ADDR_W-1 -: TAG_W];
  assign line_o    = {r_i.data, beat_buf_q};

  // address channel holds until accepted
  assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

  // slave burst length agrees with our beat count
  assert property (@(posedge clk) disable iff (!rst_n)
    beat_fire |-> (r_i.last == (beat_cnt_q == CNT_W'(LINE_WORDS - 1))));

endmodule

/* icache_lookup.sv */
`timescale 1ns/100ps

module icache_lookup import icache_pkg::*; #(
  parameter int SET_NUM    = 64,
  parameter int LINE_WORDS = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  // fetch request
  input  logic                                      req_valid_i,
  input  fetch_req_t                                req_i,
  output logic                                      req_ready_o,
  // fetch response
  output logic                                      rsp_valid_o,
  output fetch_rsp_t                                rsp_o,
  input  logic                                      rsp_ready_i,
  // way storage
  output logic [$clog2(SET_NUM)-1:0]                rd_idx_o,
  input  logic [WAY_NUM-1:0][ADDR_W-$clog2(SET_NUM)-$clog2(LINE_WORDS)-3:0] tag_rd_i,
  input  logic [WAY_NUM-1:0]                        valid_rd_i,
  input  logic [WAY_NUM-1:0][LINE_WORDS-1:0][31:0]  line_rd_i,
  input  logic                                      plru_rd_i,
  output logic                                      plru_we_o,
  output logic                                      plru_wdata_o,
  // refill
  output logic                                      miss_o,
  output logic [ADDR_W-1:0]                         miss_addr_o,
  output logic                                      victim_way_o,
  input  logic                                      refill_busy_i
);

  localparam int IDX_W     = $clog2(SET_NUM);
  localparam int OFS_W     = $clog2(LINE_WORDS) + 2;
  localparam int TAG_W     = ADDR_W - IDX_W - OFS_W;
  localparam int WORD_W    = $clog2(LINE_WORDS);
  localparam int FETCH_OFS = $clog2(FETCH_WIDTH) + 2;

  logic                       s0_adef;
  logic                       s1_ready;
  logic                       s1_en;
  logic                       s1_adef;
  logic [ADDR_W-1:0]          s1_addr;
  logic [WAY_NUM-1:0]         hit_oh;
  logic                       hit;
  logic                       hit_way;
  logic                       grp_ok;
  logic                       rsp_fire;
  logic [LINE_WORDS-1:0][31:0] hit_line;
  logic [WORD_W-1:0]          word_base;

  // ============================================================
  // stage 0
  // ============================================================
  assign s0_adef     = req_i.vaddr[1:0] != 2'b00;
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;
  // stage 1 must be empty or draining, and no refill in progress
  assign s1_ready    = !refill_busy_i && (!s1_en || rsp_fire);
  assign req_ready_o = s1_ready;

  // held index keeps the ram outputs on the stage 1 set
  assign rd_idx_o = s1_ready ? req_i.vaddr[OFS_W +: IDX_W] : s1_addr[OFS_W +: IDX_W];

  // ============================================================
  // stage 1
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_en <= 1'b0;
    end else if (flush_i) begin
      s1_en <= 1'b0;
    end else if (s1_ready) begin
      s1_en <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_addr <= req_i.vaddr;
      s1_adef <= s0_adef;
    end
  end

  // tag match
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      hit_oh[w] = valid_rd_i[w] && (tag_rd_i[w] == s1_addr[ADDR_W-1 -: TAG_W]);
    end
  end

  assign hit     = |hit_oh;
  assign hit_way = hit_oh[1];
  assign grp_ok  = hit && !s1_adef;

  // misses go to the refill, address errors never do
  assign miss_o       = s1_en && !s1_adef && !hit && !refill_busy_i;
  assign miss_addr_o  = {s1_addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign victim_way_o = plru_rd_i;

  // point the set at the way that was not used
  assign plru_we_o    = rsp_fire && grp_ok;
  assign plru_wdata_o = ~hit_way;

  // ============================================================
  // response
  // ============================================================
  assign rsp_valid_o = s1_en && (s1_adef || hit);
  assign hit_line    = line_rd_i[hit_way];
  // first word of the aligned fetch group
  assign word_base   = s1_addr[OFS_W-1:2] & ~WORD_W'(FETCH_WIDTH - 1);

  always_comb begin
    rsp_o.adef  = s1_adef;
    // keep the faulting address for an error
    rsp_o.vaddr = s1_adef ? s1_addr : {s1_addr[ADDR_W-1:FETCH_OFS], {FETCH_OFS{1'b0}}};
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      rsp_o.slot_valid[i] = grp_ok;
      rsp_o.instr[i]      = grp_ok ? hit_line[word_base + WORD_W'(i)] : '0;
    end
  end

  // a refill never fills a way while the other holds the same tag
  assert property (@(posedge clk) disable iff (!rst_n)
    s1_en |-> !(&hit_oh));

endmodule

/* icache_ways.sv */
`timescale 1ns/100ps

module icache_ways import icache_pkg::*; #(
  parameter int SET_NUM    = 64,
  parameter int LINE_WORDS = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // read side, one cycle latency
  input  logic [$clog2(SET_NUM)-1:0]                rd_idx_i,
  output logic [WAY_NUM-1:0][ADDR_W-$clog2(SET_NUM)-$clog2(LINE_WORDS)-3:0] tag_rd_o,
  output logic [WAY_NUM-1:0]                        valid_rd_o,
  output logic [WAY_NUM-1:0][LINE_WORDS-1:0][31:0]  line_rd_o,
  output logic                                      plru_rd_o,
  // line write from the refill
  input  logic                                      way_we_i,
  input  logic                                      way_sel_i,
  input  logic [$clog2(SET_NUM)-1:0]                way_idx_i,
  input  logic [ADDR_W-$clog2(SET_NUM)-$clog2(LINE_WORDS)-3:0] way_tag_i,
  input  logic [LINE_WORDS-1:0][31:0]               line_i,
  // plru update, always for the set read last cycle
  input  logic                                      plru_we_i,
  input  logic                                      plru_wdata_i
);

  localparam int IDX_W = $clog2(SET_NUM);
  localparam int OFS_W = $clog2(LINE_WORDS) + 2;
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

  logic [SET_NUM-1:0][WAY_NUM-1:0] valid_q;
  logic [SET_NUM-1:0][WAY_NUM-1:0] valid_nxt;
  logic [SET_NUM-1:0]              plru_q;
  logic [SET_NUM-1:0]              plru_nxt;
  logic [IDX_W-1:0]                rd_idx_q;
  logic [WAY_NUM-1:0]              way_we;

  // ============================================================
  // data and tag storage
  // ============================================================
  for (genvar w = 0; w < WAY_NUM; w++) begin : gen_way
    assign way_we[w] = way_we_i && (way_sel_i == w[0]);

    sdp_ram #(
      .DEPTH (SET_NUM),
      .WIDTH (LINE_WORDS * 32)
    ) u_data_ram (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (way_idx_i),
      .wdata_i (line_i),
      .raddr_i (rd_idx_i),
      .rdata_o (line_rd_o[w])
    );

    sdp_ram #(
      .DEPTH (SET_NUM),
      .WIDTH (TAG_W)
    ) u_tag_ram (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (way_idx_i),
      .wdata_i (way_tag_i),
      .raddr_i (rd_idx_i),
      .rdata_o (tag_rd_o[w])
    );
  end

  // ============================================================
  // valid and plru bits
  // ============================================================
  // next state first, so a read of the written set sees new bits
  always_comb begin
    valid_nxt = valid_q;
    plru_nxt  = plru_q;
    if (way_we_i) begin
      valid_nxt[way_idx_i][way_sel_i] = 1'b1;
    end
    if (plru_we_i) begin
      plru_nxt[rd_idx_q] = plru_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      plru_q     <= '0;
      valid_rd_o <= '0;
      plru_rd_o  <= 1'b0;
      rd_idx_q   <= '0;
    end else begin
      valid_q    <= valid_nxt;
      plru_q     <= plru_nxt;
      valid_rd_o <= valid_nxt[rd_idx_i];
      plru_rd_o  <= plru_nxt[rd_idx_i];
      rd_idx_q   <= rd_idx_i;
    end
  end

  // a hit update and a line write must not collide on one set
  assert property (@(posedge clk) disable iff (!rst_n)
    !(way_we_i && plru_we_i && (way_idx_i == rd_idx_q)));

endmodule

/* sdp_ram.sv */
`timescale 1ns/100ps

module sdp_ram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, new data wins on a collision
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* icache_pkg.sv */
package icache_pkg;

  // ============================================================
  // global widths
  // ============================================================
  localparam int ADDR_W      = 32;
  localparam int FETCH_WIDTH = 2;
  // victim choice is one bit per set, so two ways only
  localparam int WAY_NUM     = 2;

  // ============================================================
  // encodings
  // ============================================================
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

  // ============================================================
  // port payloads
  // ============================================================
  // fetch side
  typedef struct packed {
    logic [ADDR_W-1:0] vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0]                  vaddr;
    logic [FETCH_WIDTH-1:0][31:0]       instr;
    logic [FETCH_WIDTH-1:0]             slot_valid;
    logic                               adef;
  } fetch_rsp_t;

  // axi read address channel
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    axi_burst_e        burst;
  } axi_ar_t;

  // axi read data channel
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } axi_r_t;

endpackage
